// ==== flist.f ====
+incdir+src
src/leaderboard_pkg.sv
src/vga_timing.sv
src/house_points.sv
src/leaderboard.sv
src/digit_glyph.sv
src/leaderboard_top.sv
tests/leaderboard_asserts.sv
tests/leaderboard_checker.sv
tests/tb_leaderboard.sv

// ==== run.sh ====
#!/bin/sh
# build and run the leaderboard testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_leaderboard -f flist.f -o sim_leaderboard
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_leaderboard > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// ==== src/digit_glyph.sv ====
`include "leaderboard_consts.svh"

module digit_glyph import leaderboard_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  house_e     house,
	input  logic       crest,
	input  logic       in_digit,
	input  digit_t     digit,
	input  logic [4:0] gx,
	input  logic [4:0] gy,
	output color_t     rgb
);

	logic [29:0] glyph;   // 6 rows of 5, top row in the msbs
	logic [4:0]  gcol;
	logic [4:0]  grow;
	logic [4:0]  bit_idx;
	logic        pix_on;

	// 5x6 font
	always_comb
	begin
		case (digit)
			4'd0:    glyph = 30'b01110_10001_10001_10001_10001_01110;
			4'd1:    glyph = 30'b00100_01100_00100_00100_00100_01110;
			4'd2:    glyph = 30'b01110_10001_00010_00100_01000_11111;
			4'd3:    glyph = 30'b11110_00001_01110_00001_00001_11110;
			4'd4:    glyph = 30'b00010_00110_01010_10010_11111_00010;
			4'd5:    glyph = 30'b11111_10000_11110_00001_10001_01110;
			4'd6:    glyph = 30'b01110_10000_11110_10001_10001_01110;
			4'd7:    glyph = 30'b11111_00001_00010_00100_01000_01000;
			4'd8:    glyph = 30'b01110_10001_01110_10001_10001_01110;
			4'd9:    glyph = 30'b01110_10001_10001_01111_00001_01110;
			default: glyph = '0;
		endcase
	end

	assign gcol    = gx / 5'd6;   // 6 px per font column
	assign grow    = gy / 5'd5;   // 5 px per font row
	assign bit_idx = 5'd29 - (grow * 5'd5 + gcol);
	assign pix_on  = glyph[bit_idx];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rgb <= `COL_BG;
		else if (crest)
		begin
			case (house)
				HOUSE_G: rgb <= `COL_G;
				HOUSE_S: rgb <= `COL_S;
				HOUSE_R: rgb <= `COL_R;
				HOUSE_H: rgb <= `COL_H;
				default: rgb <= `COL_BG;
			endcase
		end
		else if (in_digit && pix_on)
			rgb <= `COL_FG;
		else
			rgb <= `COL_BG;
	end

endmodule

// ==== src/house_points.sv ====
`include "leaderboard_consts.svh"

module house_points import leaderboard_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  score_t score,
	output digit_t d0,   // ones
	output digit_t d1,
	output digit_t d2,
	output digit_t d3,
	output digit_t d4,
	output digit_t d5    // hundred-thousands
);

	conv_state_e        state;
	logic [4:0]         shift_cnt;
	score_t             sh;
	logic [4*`NUM_DIGITS-1:0] bcd;
	logic [4*`NUM_DIGITS-1:0] bcd_adj;

	// add 3 to each nibble of 5 or more before the shift
	always_comb
	begin
		bcd_adj = bcd;
		for (int i = 0; i < `NUM_DIGITS; i++)
			if (bcd[4*i +: 4] >= 4'd5)
				bcd_adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= CONV_LOAD;
			shift_cnt <= '0;
		end
		else
		begin
			case (state)
				CONV_LOAD:  state <= CONV_SHIFT;
				CONV_SHIFT:
				begin
					shift_cnt <= shift_cnt + 1'b1;
					if (shift_cnt == 5'(`SCORE_BITS - 1))
						state <= CONV_DONE;
				end
				default:    state <= CONV_LOAD;   // done, start next pass
			endcase
			if (state == CONV_LOAD)
				shift_cnt <= '0;
		end
	end

	// datapath, no reset
	always_ff @(posedge clk)
	begin
		if (state == CONV_LOAD)
		begin
			sh  <= score;   // sample once per pass
			bcd <= '0;
		end
		else if (state == CONV_SHIFT)
		begin
			bcd <= {bcd_adj[4*`NUM_DIGITS-2:0], sh[`SCORE_BITS-1]};
			sh  <= {sh[`SCORE_BITS-2:0], 1'b0};
		end
	end

	// shown digits only change on a finished pass
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			{d5, d4, d3, d2, d1, d0} <= '0;
		end
		else if (state == CONV_DONE)
		begin
			{d5, d4, d3, d2, d1, d0} <= bcd;
		end
	end

endmodule

// ==== src/leaderboard.sv ====
`include "leaderboard_consts.svh"

module leaderboard import leaderboard_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   enable,
	input  row_t   row,
	input  col_t   col,
	input  digit_t g_d0, g_d1, g_d2, g_d3, g_d4, g_d5,
	input  digit_t s_d0, s_d1, s_d2, s_d3, s_d4, s_d5,
	input  digit_t r_d0, r_d1, r_d2, r_d3, r_d4, r_d5,
	input  digit_t h_d0, h_d1, h_d2, h_d3, h_d4, h_d5,
	output house_e house,
	output logic   crest,
	output logic   in_digit,
	output digit_t digit,
	output logic [4:0] gx,
	output logic [4:0] gy
);

	// per house, index 0 is the leftmost cell
	digit_t g_set [`NUM_DIGITS];
	digit_t s_set [`NUM_DIGITS];
	digit_t r_set [`NUM_DIGITS];
	digit_t h_set [`NUM_DIGITS];
	digit_t cur_set [`NUM_DIGITS];

	house_e     band;
	row_t       band_top;
	row_t       rel_row;     // row inside the band
	logic [2:0] place;
	col_t       cell_start;
	logic       cell_col_hit;
	logic       cell_row_hit;
	logic       crest_hit;

	assign g_set = '{g_d5, g_d4, g_d3, g_d2, g_d1, g_d0};
	assign s_set = '{s_d5, s_d4, s_d3, s_d2, s_d1, s_d0};
	assign r_set = '{r_d5, r_d4, r_d3, r_d2, r_d1, r_d0};
	assign h_set = '{h_d5, h_d4, h_d3, h_d2, h_d1, h_d0};

	// band select
	always_comb
	begin
		band     = HOUSE_NONE;
		band_top = '0;
		for (int i = 0; i < `NUM_BANDS; i++)
			if (row >= row_t'(`BAND_TOP + `BAND_HEIGHT * i) &&
				row < row_t'(`BAND_TOP + `BAND_HEIGHT * (i + 1)))
			begin
				band     = house_e'(i);
				band_top = row_t'(`BAND_TOP + `BAND_HEIGHT * i);
			end
	end

	assign rel_row = row - band_top;

	// which of the six cells, and where it starts
	always_comb
	begin
		place        = '0;
		cell_start   = col_t'(`DIGIT_COL0);
		cell_col_hit = 1'b0;
		for (int i = 0; i < `NUM_DIGITS; i++)
			if (col >= col_t'(`DIGIT_COL0 + `CELL * i) &&
				col < col_t'(`DIGIT_COL0 + `CELL * (i + 1)))
			begin
				place        = 3'(i);
				cell_start   = col_t'(`DIGIT_COL0 + `CELL * i);
				cell_col_hit = 1'b1;
			end
	end

	assign cell_row_hit = (rel_row >= row_t'(`DIGIT_ROW_OFS)) &&
		(rel_row < row_t'(`DIGIT_ROW_OFS + `CELL));
	assign crest_hit = (col >= col_t'(`CREST_COL0)) && (col < col_t'(`CREST_COL1));

	// house / place mux
	always_comb
	begin
		case (band)
			HOUSE_G: cur_set = g_set;
			HOUSE_S: cur_set = s_set;
			HOUSE_R: cur_set = r_set;
			default: cur_set = h_set;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			house    <= HOUSE_NONE;
			crest    <= 1'b0;
			in_digit <= 1'b0;
		end
		else
		begin
			house    <= enable ? band : HOUSE_NONE;
			crest    <= enable && (band != HOUSE_NONE) && crest_hit;
			in_digit <= enable && (band != HOUSE_NONE) && cell_row_hit && cell_col_hit;
		end
	end

	// payload only means something with in_digit set
	always_ff @(posedge clk)
	begin
		digit <= cur_set[place];
		gx    <= 5'(col - cell_start);
		gy    <= 5'(rel_row - row_t'(`DIGIT_ROW_OFS));
	end

endmodule

// ==== src/leaderboard_consts.svh ====
`ifndef LEADERBOARD_CONSTS_SVH
`define LEADERBOARD_CONSTS_SVH

// 640x480 raster, 800x525 total, syncs active low
`define H_ACTIVE      640
`define H_SYNC_START  656
`define H_SYNC_END    752
`define H_TOTAL       800
`define V_ACTIVE      480
`define V_SYNC_START  490
`define V_SYNC_END    492
`define V_TOTAL       525

// four house bands stacked G, S, R, H
`define NUM_BANDS     4
`define BAND_TOP      40
`define BAND_HEIGHT   100

`define DIGIT_ROW_OFS 35    // from band top
`define DIGIT_COL0    280
`define CELL          30
`define NUM_DIGITS    6

`define CREST_COL0    120
`define CREST_COL1    220   // exclusive

// 4:4:4 rgb
`define COL_G         12'hF00
`define COL_S         12'h0F0
`define COL_R         12'h00F
`define COL_H         12'hFF0
`define COL_FG        12'hFFF
`define COL_BG        12'h000

`define SCORE_BITS    20

`endif

// ==== src/leaderboard_pkg.sv ====
`include "leaderboard_consts.svh"

package leaderboard_pkg;

	typedef logic [`SCORE_BITS-1:0] score_t;   // binary house score
	typedef logic [3:0]  digit_t;              // one bcd digit
	typedef logic [9:0]  row_t;
	typedef logic [9:0]  col_t;
	typedef logic [11:0] color_t;

	// band order follows the screen from top to bottom
	typedef enum logic [2:0]
	{
		HOUSE_G    = 3'd0,
		HOUSE_S    = 3'd1,
		HOUSE_R    = 3'd2,
		HOUSE_H    = 3'd3,
		HOUSE_NONE = 3'd4
	} house_e;

	typedef enum logic [1:0]
	{
		CONV_LOAD  = 2'd0,
		CONV_SHIFT = 2'd1,
		CONV_DONE  = 2'd2
	} conv_state_e;

endpackage

// ==== src/leaderboard_top.sv ====
module leaderboard_top import leaderboard_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   leaderboard,
	input  score_t g_score,
	input  score_t s_score,
	input  score_t r_score,
	input  score_t h_score,
	output color_t rgb,
	output logic   hsync,
	output logic   vsync,
	output logic   de
);

	row_t       row;
	col_t       col;
	logic       hsync_t, vsync_t, de_t;
	logic       hsync_d, vsync_d, de_d;
	digit_t     g_d [6];
	digit_t     s_d [6];
	digit_t     r_d [6];
	digit_t     h_d [6];
	house_e     house;
	logic       crest, in_digit;
	digit_t     digit;
	logic [4:0] gx, gy;

	vga_timing u_timing (.clk, .rst_n, .row, .col, .hsync(hsync_t), .vsync(vsync_t), .de(de_t));

	house_points u_hp_g (.clk, .rst_n, .score(g_score), .d0(g_d[0]), .d1(g_d[1]),
		.d2(g_d[2]), .d3(g_d[3]), .d4(g_d[4]), .d5(g_d[5]));
	house_points u_hp_s (.clk, .rst_n, .score(s_score), .d0(s_d[0]), .d1(s_d[1]),
		.d2(s_d[2]), .d3(s_d[3]), .d4(s_d[4]), .d5(s_d[5]));
	house_points u_hp_r (.clk, .rst_n, .score(r_score), .d0(r_d[0]), .d1(r_d[1]),
		.d2(r_d[2]), .d3(r_d[3]), .d4(r_d[4]), .d5(r_d[5]));
	house_points u_hp_h (.clk, .rst_n, .score(h_score), .d0(h_d[0]), .d1(h_d[1]),
		.d2(h_d[2]), .d3(h_d[3]), .d4(h_d[4]), .d5(h_d[5]));

	leaderboard u_overlay (
		.clk, .rst_n, .enable(leaderboard), .row, .col,
		.g_d0(g_d[0]), .g_d1(g_d[1]), .g_d2(g_d[2]), .g_d3(g_d[3]), .g_d4(g_d[4]), .g_d5(g_d[5]),
		.s_d0(s_d[0]), .s_d1(s_d[1]), .s_d2(s_d[2]), .s_d3(s_d[3]), .s_d4(s_d[4]), .s_d5(s_d[5]),
		.r_d0(r_d[0]), .r_d1(r_d[1]), .r_d2(r_d[2]), .r_d3(r_d[3]), .r_d4(r_d[4]), .r_d5(r_d[5]),
		.h_d0(h_d[0]), .h_d1(h_d[1]), .h_d2(h_d[2]), .h_d3(h_d[3]), .h_d4(h_d[4]), .h_d5(h_d[5]),
		.house, .crest, .in_digit, .digit, .gx, .gy);

	digit_glyph u_glyph (.clk, .rst_n, .house, .crest, .in_digit, .digit, .gx, .gy, .rgb);

	// match the overlay and glyph register stages
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			{hsync_d, vsync_d, de_d} <= 3'b110;
			{hsync, vsync, de}       <= 3'b110;
		end
		else
		begin
			{hsync_d, vsync_d, de_d} <= {hsync_t, vsync_t, de_t};
			{hsync, vsync, de}       <= {hsync_d, vsync_d, de_d};
		end
	end

endmodule

// ==== src/vga_timing.sv ====
`include "leaderboard_consts.svh"

module vga_timing import leaderboard_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output row_t row,
	output col_t col,
	output logic hsync,
	output logic vsync,
	output logic de
);

	col_t col_next;
	row_t row_next;

	always_comb
	begin
		col_next = (col == col_t'(`H_TOTAL - 1)) ? '0 : col + 1'b1;
		row_next = row;
		if (col == col_t'(`H_TOTAL - 1))
			row_next = (row == row_t'(`V_TOTAL - 1)) ? '0 : row + 1'b1;
	end

	// syncs and de decoded from the next position so they line up with row/col
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// park on the last blanking pixel, first clock out of reset gives 0,0
			col   <= col_t'(`H_TOTAL - 1);
			row   <= row_t'(`V_TOTAL - 1);
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end
		else
		begin
			col   <= col_next;
			row   <= row_next;
			hsync <= !(col_next >= col_t'(`H_SYNC_START) && col_next < col_t'(`H_SYNC_END));
			vsync <= !(row_next >= row_t'(`V_SYNC_START) && row_next < row_t'(`V_SYNC_END));
			de    <= (col_next < col_t'(`H_ACTIVE)) && (row_next < row_t'(`V_ACTIVE));
		end
	end

endmodule

// ==== tests/leaderboard_asserts.sv ====
module leaderboard_asserts import leaderboard_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        hsync,
	input logic        vsync,
	input logic        de,
	input score_t      g_score,
	input score_t      s_score,
	input score_t      r_score,
	input score_t      h_score,
	input conv_state_e g_state,
	input conv_state_e s_state,
	input conv_state_e r_state,
	input conv_state_e h_state
);

	localparam score_t SCORE_MAX = score_t'(999999);

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		g_state inside {CONV_LOAD, CONV_SHIFT, CONV_DONE} &&
		s_state inside {CONV_LOAD, CONV_SHIFT, CONV_DONE} &&
		r_state inside {CONV_LOAD, CONV_SHIFT, CONV_DONE} &&
		h_state inside {CONV_LOAD, CONV_SHIFT, CONV_DONE})
		else $error("converter state outside its encoding");

	de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
		de |-> (hsync && vsync))
		else $error("de high during a sync pulse");

	score_range: assert property (@(posedge clk)
		g_score <= SCORE_MAX && s_score <= SCORE_MAX &&
		r_score <= SCORE_MAX && h_score <= SCORE_MAX)
		else $error("score input above 999999");

endmodule

// ==== tests/leaderboard_checker.sv ====
`include "leaderboard_consts.svh"

module leaderboard_checker import leaderboard_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   leaderboard,
	input  score_t g_score,
	input  score_t s_score,
	input  score_t r_score,
	input  score_t h_score,
	input  color_t rgb,
	input  logic   hsync,
	input  logic   vsync,
	input  logic   de,
	output row_t   mrow,
	output col_t   mcol,
	output int     err_count,
	output int     check_count
);

	logic [29:0] font [10];   // 6 rows of 5, top row first
	color_t      exp_rgb [2];
	logic [2:0]  exp_sync [2];   // hsync, vsync, de

	initial
	begin
		font[0] = 30'b01110_10001_10001_10001_10001_01110;
		font[1] = 30'b00100_01100_00100_00100_00100_01110;
		font[2] = 30'b01110_10001_00010_00100_01000_11111;
		font[3] = 30'b11110_00001_01110_00001_00001_11110;
		font[4] = 30'b00010_00110_01010_10010_11111_00010;
		font[5] = 30'b11111_10000_11110_00001_10001_01110;
		font[6] = 30'b01110_10000_11110_10001_10001_01110;
		font[7] = 30'b11111_00001_00010_00100_01000_01000;
		font[8] = 30'b01110_10001_01110_10001_10001_01110;
		font[9] = 30'b01110_10001_10001_01111_00001_01110;
		for (int i = 0; i < 2; i++)
		begin
			exp_rgb[i]  = `COL_BG;
			exp_sync[i] = 3'b110;   // reset values
		end
		err_count   = 0;
		check_count = 0;
	end

	// model raster, (0,0) on the first clock out of reset
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			mcol <= col_t'(`H_TOTAL - 1);
			mrow <= row_t'(`V_TOTAL - 1);
		end
		else if (mcol == col_t'(`H_TOTAL - 1))
		begin
			mcol <= '0;
			mrow <= (mrow == row_t'(`V_TOTAL - 1)) ? '0 : mrow + 1'b1;
		end
		else
			mcol <= mcol + 1'b1;
	end

	// place 0 is the hundred-thousands digit
	function automatic int digit_of(score_t score, int place);
		int div;
		div = 1;
		for (int i = place; i < 5; i++)
			div = div * 10;
		return (int'(score) / div) % 10;
	endfunction

	function automatic color_t expect_pixel(int r, int c);
		int band;
		int top;
		int gx;
		int gy;
		int d;
		if (!leaderboard || r >= `V_ACTIVE || c >= `H_ACTIVE)
			return `COL_BG;
		if (r < `BAND_TOP || r >= `BAND_TOP + `NUM_BANDS * `BAND_HEIGHT)
			return `COL_BG;
		band = (r - `BAND_TOP) / `BAND_HEIGHT;
		top  = `BAND_TOP + band * `BAND_HEIGHT;
		if (c >= `CREST_COL0 && c < `CREST_COL1)
		begin
			case (band)
				0:       return `COL_G;
				1:       return `COL_S;
				2:       return `COL_R;
				default: return `COL_H;
			endcase
		end
		if (r < top + `DIGIT_ROW_OFS || r >= top + `DIGIT_ROW_OFS + `CELL)
			return `COL_BG;
		if (c < `DIGIT_COL0 || c >= `DIGIT_COL0 + `NUM_DIGITS * `CELL)
			return `COL_BG;
		gx = (c - `DIGIT_COL0) % `CELL;
		gy = r - top - `DIGIT_ROW_OFS;
		case (band)
			0:       d = digit_of(g_score, (c - `DIGIT_COL0) / `CELL);
			1:       d = digit_of(s_score, (c - `DIGIT_COL0) / `CELL);
			2:       d = digit_of(r_score, (c - `DIGIT_COL0) / `CELL);
			default: d = digit_of(h_score, (c - `DIGIT_COL0) / `CELL);
		endcase
		return font[d][29 - (gy / 5) * 5 - gx / 6] ? `COL_FG : `COL_BG;
	endfunction

	task automatic report_mismatch(input string name, input logic [11:0] expv,
		input logic [11:0] got);
		$display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expv, got);
		err_count++;
	endtask

	// outputs lag the raster by two clocks, so compare against the entry from two back
	always @(negedge clk)
	begin
		int r;
		int c;
		r = int'(mrow);
		c = int'(mcol);
		check_count++;
		if (rgb !== exp_rgb[1])
			report_mismatch("rgb", exp_rgb[1], rgb);
		if (hsync !== exp_sync[1][2])
			report_mismatch("hsync", 12'(exp_sync[1][2]), 12'(hsync));
		if (vsync !== exp_sync[1][1])
			report_mismatch("vsync", 12'(exp_sync[1][1]), 12'(vsync));
		if (de !== exp_sync[1][0])
			report_mismatch("de", 12'(exp_sync[1][0]), 12'(de));
		exp_rgb[1]  = exp_rgb[0];
		exp_sync[1] = exp_sync[0];
		exp_rgb[0]  = expect_pixel(r, c);
		exp_sync[0] = {!(c >= `H_SYNC_START && c < `H_SYNC_END),
			!(r >= `V_SYNC_START && r < `V_SYNC_END),
			(c < `H_ACTIVE && r < `V_ACTIVE)};
	end

endmodule

// ==== tests/tb_leaderboard.sv ====
`include "leaderboard_consts.svh"

module tb_leaderboard import leaderboard_pkg::*;
();

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int NUM_FRAMES   = 6;
	localparam int TIMEOUT      = NUM_FRAMES * FRAME_CYCLES + 1000;

	logic   clk;
	logic   rst_n;
	logic   leaderboard;
	score_t g_score;
	score_t s_score;
	score_t r_score;
	score_t h_score;
	color_t rgb;
	logic   hsync;
	logic   vsync;
	logic   de;
	row_t   mrow;
	col_t   mcol;
	int     err_count;
	int     check_count;
	int     cycles;
	int     seed;

	leaderboard_top u_dut (.clk, .rst_n, .leaderboard, .g_score, .s_score, .r_score, .h_score,
		.rgb, .hsync, .vsync, .de);

	leaderboard_checker u_checker (.clk, .rst_n, .leaderboard, .g_score, .s_score, .r_score,
		.h_score, .rgb, .hsync, .vsync, .de, .mrow, .mcol, .err_count, .check_count);

	bind leaderboard_top leaderboard_asserts u_asserts (
		.clk, .rst_n, .hsync, .vsync, .de, .g_score, .s_score, .r_score, .h_score,
		.g_state(u_hp_g.state), .s_state(u_hp_s.state),
		.r_state(u_hp_r.state), .h_state(u_hp_h.state));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic score_t rand_score();
		return score_t'($unsigned($random(seed)) % 1000000);
	endfunction

	// first pixel of vertical blanking in the model raster
	task automatic wait_vblank();
		do
			@(posedge clk);
		while (!(mrow == row_t'(`V_ACTIVE) && mcol == '0));
	endtask

	task automatic apply_frame(input int frame);
		g_score <= (frame == 1) ? score_t'(999999) : rand_score();
		s_score <= rand_score();
		r_score <= rand_score();
		h_score <= (frame == 1) ? score_t'($unsigned($random(seed)) % 1000) : rand_score();
		if (frame == 2)
			leaderboard <= 1'b0;   // one blank frame for sure
		else if (frame == 1 || frame == 4)
			leaderboard <= 1'b1;   // 999999 and leading zeros on screen
		else
			leaderboard <= 1'($random(seed));
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		seed        = 56367;
		rst_n       = 1'b0;
		leaderboard = 1'b1;
		g_score     = rand_score();
		s_score     = rand_score();
		r_score     = rand_score();
		h_score     = rand_score();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (int f = 1; f < NUM_FRAMES; f++)
		begin
			wait_vblank();
			apply_frame(f);
		end
		wait_vblank();   // last frame fully drawn
		$display("checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
